// File: board_ctrl.f
+incdir+logic
logic/board_pkg.sv
logic/reg_bus_if.sv
logic/host_reg_port.sv
logic/board_regs.sv
logic/watchdog_timer.sv
logic/board_ctrl_top.sv
dv/board_ctrl_tb.sv

// File: dv/board_ctrl_tb.sv
/*
 * testbench for the board register block
 *   clock, reset and host four-phase handshake
 *   typed compare tasks, xorshift stimulus, run watchdog
 *   directed tests: identity, masked enables, readback,
 *   prom mailbox, watchdog expiry
 */

`timescale 1ns/1ps

`include "board_defines.svh"

module board_ctrl_tb;

    localparam int clk_period = 20;
    localparam int tick       = 1 << `WDOG_TICK_BITS;   // sysclk cycles per watchdog tick
    localparam int margin     = 8;
    localparam int access_max = 16;                     // cycles allowed per handshake edge
    // about 60 accesses, the expiry window and the long period 0 wait
    localparam int budget     = 10 + 80 * 2 * access_max + 5 * tick + 16 * tick + 200;

    logic sysclk, reset, host_req, host_we, host_ack;
    board_pkg::reg_addr_t  host_addr;
    board_pkg::reg_word_t  host_wdata, host_rdata, prom_result, prom_cmd;
    board_pkg::axis_vec_t  neg_limit, pos_limit, home, fault, amp_disable, dout;
    logic relay, mv_good, v_fault, prom_cmd_clear, pwr_enable, relay_on;
    logic [3:0]  board_id;
    logic [15:0] temp_sense;

    logic [31:0]          rng = 32'd74978;
    board_pkg::axis_vec_t model_dis;      // expected stored disables
    logic                 model_relay;
    string                cur_test;
    int errors = 0, tests_run = 0, tests_failed = 0, errs_at_start;

    board_ctrl_top DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #(clk_period / 2) sysclk = ~sysclk;
    end

    // ends a hung run
    initial begin
        #(budget * clk_period);
        $display("run did not finish within %0d cycles, stopping", budget);
        $display("Regression failed");
        $finish;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic board_pkg::reg_word_t next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // status layout from the register map
    function automatic board_pkg::reg_word_t expected_status(input logic tmo);
        board_pkg::reg_word_t s;
        s                    = '0;
        s[`STAT_PWR_BIT]     = 1'b1;           // power never dropped here
        s[`STAT_RELAY_BIT]   = model_relay;
        s[27:24]             = board_id;
        s[`STAT_TIMEOUT_BIT] = tmo;
        s[19:16]             = fault;
        s[3:0]               = ~model_dis;     // enables
        return s;
    endfunction

    task automatic check_word(input string what, input board_pkg::reg_word_t exp,
                              input board_pkg::reg_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %08h actual %08h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_axis(input string what, input board_pkg::axis_vec_t exp,
                              input board_pkg::axis_vec_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %04b actual %04b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // full req/ack cycle with outputs sampled on falling edges
    task automatic host_access(input logic we, input board_pkg::reg_addr_t addr,
                               input board_pkg::reg_word_t wdata,
                               output board_pkg::reg_word_t rdata);
        int n;
        n = 0;
        @(posedge sysclk);
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        host_req   <= 1'b1;
        @(negedge sysclk);
        while (!host_ack && n < access_max) begin
            @(negedge sysclk);
            n++;
        end
        if (!host_ack) begin
            $display("%s: host_ack never rose for address %02h", cur_test, addr);
            errors++;
        end
        rdata = host_rdata;
        @(posedge sysclk);
        host_req <= 1'b0;                      // host lets go in phase 3
        n = 0;
        @(negedge sysclk);
        while (host_ack && n < access_max) begin
            @(negedge sysclk);
            n++;
        end
        if (host_ack) begin
            $display("%s: host_ack stuck high after host_req dropped", cur_test);
            errors++;
        end
    endtask

    task automatic host_write(input board_pkg::reg_addr_t addr, input board_pkg::reg_word_t d);
        board_pkg::reg_word_t ignored;         // prior value goes unchecked
        host_access(1'b1, addr, d, ignored);
    endtask

    task automatic host_read(input board_pkg::reg_addr_t addr, output board_pkg::reg_word_t d);
        host_access(1'b0, addr, '0, d);
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", cur_test, errors - errs_at_start);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_identity();
        board_pkg::reg_word_t rd;
        begin_test("reset_identity");
        check_axis("amp_disable", 4'b1111, amp_disable);   // all axes off
        check_bit("pwr_enable", 1'b1, pwr_enable);
        check_bit("relay_on", 1'b0, relay_on);
        check_word("prom_cmd", '0, prom_cmd);
        host_read({4'h0, `REG_VERSION}, rd);
        check_word("version", `BOARD_VERSION, rd);
        host_read({4'h0, `REG_FW_VERSION}, rd);
        check_word("fw version", `FW_VERSION, rd);
        host_read({4'h0, `REG_TEMPSNS}, rd);
        check_word("temp", {16'd0, temp_sense}, rd);
        host_read({4'h0, `REG_STATUS}, rd);
        check_word("status", expected_status(1'b0), rd);
        report_test();
    endtask

    task automatic masked_enables();
        board_pkg::reg_word_t w, rd;
        begin_test("masked_enables");
        for (int k = 0; k < 8; k++) begin
            // first pass enables all axes and the second turns axes 0 and 1 off with relay
            w = (k == 0) ? 32'h0000_0F0F : (k == 1) ? 32'h0001_0300 : next_random();
            host_write({4'h0, `REG_STATUS}, w);
            for (int i = 0; i < 4; i++) begin
                if (w[8 + i]) model_dis[i] = ~w[i];     // unmasked axes hold
            end
            model_relay = w[16];
            check_axis("amp_disable", model_dis, amp_disable);
            check_bit("relay_on", model_relay, relay_on);
            host_read({4'h0, `REG_STATUS}, rd);
            check_word("status", expected_status(1'b0), rd);
        end
        report_test();
    endtask

    task automatic readback_regs();
        board_pkg::reg_word_t v, rd;
        begin_test("readback_regs");
        for (int k = 0; k < 4; k++) begin
            v = next_random();
            host_write({4'h0, `REG_DIGIOUT}, v);
            check_axis("dout pins", v[3:0], dout);
            host_read({4'h0, `REG_DIGIOUT}, rd);
            check_word("digiout", {28'd0, v[3:0]}, rd);
            v = next_random();
            host_write({4'h0, `REG_TIMEOUT}, v);
            host_read({4'h0, `REG_TIMEOUT}, rd);
            check_word("period", {16'd0, v[15:0]}, rd);
        end
        host_write({4'h0, `REG_TIMEOUT}, '0);         // watchdog back off
        v        = '0;                                 // packed board inputs
        v[14]    = relay;
        v[13]    = mv_good;
        v[12]    = v_fault;
        v[11:8]  = neg_limit;
        v[7:4]   = pos_limit;
        v[3:0]   = home;
        host_read(8'h0B, rd);                          // unused index
        check_word("undefined index", v, rd);
        host_read(8'h10, rd);                          // channel 1
        check_word("channel 1", v, rd);
        report_test();
    endtask

    task automatic prom_mailbox();
        board_pkg::reg_word_t c, rd;
        begin_test("prom_mailbox");
        c = next_random();
        host_write({4'h0, `REG_PROMCMD}, c);
        check_word("prom_cmd pins", c, prom_cmd);
        host_read({4'h0, `REG_PROMCMD}, rd);
        check_word("promcmd read", c, rd);
        @(posedge sysclk);
        prom_cmd_clear <= 1'b1;                        // one cycle pulse
        @(posedge sysclk);
        prom_cmd_clear <= 1'b0;
        @(negedge sysclk);
        check_word("prom_cmd cleared", '0, prom_cmd);
        c = next_random();
        @(posedge sysclk);
        prom_result <= c;
        host_read({4'h0, `REG_PROMRES}, rd);
        check_word("promres read", c, rd);
        report_test();
    endtask

    task automatic watchdog_expiry();
        board_pkg::reg_word_t rd;
        begin_test("watchdog_expiry");
        host_write({4'h0, `REG_TIMEOUT}, 32'd3);
        host_write({4'h0, `REG_STATUS}, 32'h0000_0F05);   // last write starts the window
        model_dis   = 4'b1010;
        model_relay = 1'b0;
        repeat (3 * tick - margin) @(negedge sysclk);
        check_axis("disable before expiry", model_dis, amp_disable);
        repeat (tick + 2 * margin) @(negedge sysclk);
        check_axis("disable after expiry", 4'b1111, amp_disable);
        host_read({4'h0, `REG_STATUS}, rd);               // reads keep it expired
        check_word("status expired", expected_status(1'b1), rd);
        host_write({4'h0, `REG_STATUS}, 32'h0000_0F05);
        check_axis("disable after write", model_dis, amp_disable);
        host_read({4'h0, `REG_STATUS}, rd);
        check_word("status cleared", expected_status(1'b0), rd);
        host_write({4'h0, `REG_TIMEOUT}, '0);             // period 0 turns the watchdog off
        repeat (16 * tick) @(negedge sysclk);
        check_axis("disable with period 0", model_dis, amp_disable);
        host_read({4'h0, `REG_STATUS}, rd);
        check_word("status with period 0", expected_status(1'b0), rd);
        report_test();
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        reset          <= 1'b0;
        host_req       <= 1'b0;
        host_we        <= 1'b0;
        host_addr      <= '0;
        host_wdata     <= '0;
        neg_limit      <= 4'h3;
        pos_limit      <= 4'hC;
        home           <= 4'h6;
        fault          <= 4'h5;
        relay          <= 1'b1;
        mv_good        <= 1'b1;
        v_fault        <= 1'b0;
        board_id       <= 4'hA;
        temp_sense     <= 16'h1A2B;
        prom_cmd_clear <= 1'b0;
        prom_result    <= '0;
        model_dis       = 4'b1111;
        model_relay     = 1'b0;
        repeat (10) @(posedge sysclk);
        reset <= 1'b1;
        @(negedge sysclk);
        reset_identity();
        masked_enables();
        readback_regs();
        prom_mailbox();
        watchdog_expiry();
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: logic/board_ctrl_top.sv
/*
 * board register block top level
 *   host handshake port, channel 0 register file, watchdog
 *   joined by the internal register bus
 */

`timescale 1ns/1ps

module board_ctrl_top (
    input  logic                 sysclk,
    input  logic                 reset,            // sync, active low
    // host handshake
    input  logic                 host_req,
    input  logic                 host_we,
    input  board_pkg::reg_addr_t host_addr,
    input  board_pkg::reg_word_t host_wdata,
    output logic                 host_ack,
    output board_pkg::reg_word_t host_rdata,
    // board inputs
    input  board_pkg::axis_vec_t neg_limit,
    input  board_pkg::axis_vec_t pos_limit,
    input  board_pkg::axis_vec_t home,
    input  board_pkg::axis_vec_t fault,
    input  logic                 relay,
    input  logic                 mv_good,
    input  logic                 v_fault,
    input  logic [3:0]           board_id,
    input  logic [15:0]          temp_sense,
    input  logic                 prom_cmd_clear,
    input  board_pkg::reg_word_t prom_result,
    // board outputs
    output board_pkg::axis_vec_t amp_disable,
    output board_pkg::axis_vec_t dout,
    output logic                 pwr_enable,
    output logic                 relay_on,
    output board_pkg::reg_word_t prom_cmd
);

    reg_bus_if bus ();

    logic                   timeout;       // watchdog to register file
    board_pkg::wdog_count_t wdog_period;   // register file to watchdog

    host_reg_port u_port (
        .sysclk     (sysclk),
        .reset      (reset),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .bus        (bus.master)
    );

    board_regs u_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .timeout        (timeout),
        .neg_limit      (neg_limit),
        .pos_limit      (pos_limit),
        .home           (home),
        .fault          (fault),
        .relay          (relay),
        .mv_good        (mv_good),
        .v_fault        (v_fault),
        .board_id       (board_id),
        .temp_sense     (temp_sense),
        .prom_cmd_clear (prom_cmd_clear),
        .prom_result    (prom_result),
        .prom_cmd       (prom_cmd),
        .amp_disable    (amp_disable),
        .dout           (dout),
        .pwr_enable     (pwr_enable),
        .relay_on       (relay_on),
        .wdog_period    (wdog_period),
        .bus            (bus.slave)
    );

    watchdog_timer u_wdog (
        .sysclk  (sysclk),
        .reset   (reset),
        .period  (wdog_period),
        .timeout (timeout),
        .bus     (bus.monitor)
    );

endmodule

// File: logic/board_defines.svh
/*
 * board register map for channel 0
 * version constants
 * watchdog tick divider width
 * status word bit positions
 */

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ----------------------------------------------------------
// channel 0 register indices (lower address nibble)
// ----------------------------------------------------------
`define REG_STATUS      4'd0    // enables, relay, id, fault
`define REG_TIMEOUT     4'd3    // watchdog period in ticks
`define REG_VERSION     4'd4    // hard-wired board version
`define REG_TEMPSNS     4'd5    // temperature sensors
`define REG_DIGIOUT     4'd6    // digital outputs
`define REG_FW_VERSION  4'd7    // firmware version
`define REG_PROMCMD     4'd8    // prom command mailbox
`define REG_PROMRES     4'd9    // prom result, read only

// ----------------------------------------------------------
// identity constants
// ----------------------------------------------------------
`define BOARD_VERSION   32'h514C4131    // "QLA1"
`define FW_VERSION      32'h00000001

// log2 of sysclk cycles per watchdog tick
`define WDOG_TICK_BITS  4

// ----------------------------------------------------------
// status word bit positions
// ----------------------------------------------------------
`define STAT_PWR_BIT        29
`define STAT_RELAY_BIT      28
`define STAT_TIMEOUT_BIT    23

`endif

// File: logic/board_pkg.sv
/*
 * shared types of the board register block
 *   register data word and host address
 *   per-axis bit vector
 *   watchdog period and count
 *   host port FSM states
 */

package board_pkg;

    // ----------------------------------------------------------
    // data path widths
    // ----------------------------------------------------------

    // one register word as seen by the host
    typedef logic [31:0] reg_word_t;

    // [7:4] channel, [3:0] register index
    typedef logic [7:0] reg_addr_t;

    // one bit per amplifier axis
    // used for enables, disables, limits, home, fault, dout
    typedef logic [3:0] axis_vec_t;

    // watchdog period and tick counter
    typedef logic [15:0] wdog_count_t;

    // ----------------------------------------------------------
    // host port handshake states
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,       // waiting for req
        ACCESS,     // strobe on internal bus
        RESPOND,    // read data valid, capture it
        RELEASE     // ack high until req drops
    } port_state_t;

endpackage

// File: logic/board_regs.sv
/*
 * channel 0 board register file
 *   write decode with masked per-axis enables and relay control
 *   watchdog period, digital outputs, prom command mailbox
 *   registered read mux over version, temperature and board inputs
 *   amplifier disables forced on watchdog timeout
 */

`timescale 1ns/1ps

`include "board_defines.svh"

module board_regs (
    input  logic                   sysclk,
    input  logic                   reset,          // sync, active low
    input  logic                   timeout,        // from watchdog
    // board inputs
    input  board_pkg::axis_vec_t   neg_limit,
    input  board_pkg::axis_vec_t   pos_limit,
    input  board_pkg::axis_vec_t   home,
    input  board_pkg::axis_vec_t   fault,
    input  logic                   relay,
    input  logic                   mv_good,
    input  logic                   v_fault,
    input  logic [3:0]             board_id,
    input  logic [15:0]            temp_sense,
    // prom mailbox
    input  logic                   prom_cmd_clear,
    input  board_pkg::reg_word_t   prom_result,
    output board_pkg::reg_word_t   prom_cmd,
    // board outputs
    output board_pkg::axis_vec_t   amp_disable,
    output board_pkg::axis_vec_t   dout,
    output logic                   pwr_enable,
    output logic                   relay_on,
    output board_pkg::wdog_count_t wdog_period,    // to watchdog
    reg_bus_if.slave               bus
);

    board_pkg::axis_vec_t reg_disable;     // stored per-axis disables
    board_pkg::reg_word_t status_word;
    board_pkg::reg_word_t rd_mux;
    logic                 ch0;             // channel 0 selected
    logic [3:0]           idx;

    assign ch0 = (bus.addr[7:4] == 4'd0);
    assign idx = bus.addr[3:0];

    // ----------------------------------------------------------
    // write decode
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;     // all axes start disabled
            pwr_enable  <= 1'b1;   // motor power stays on
            relay_on    <= 1'b0;
            wdog_period <= '0;     // watchdog off
            dout        <= '0;
            prom_cmd    <= '0;
        end else begin
            if (bus.wr_en && ch0) begin
                case (idx)
                    `REG_STATUS: begin
                        // [11:8] pick the axes and [3:0] hold the enables
                        for (int i = 0; i < 4; i++) begin
                            if (bus.wdata[8 + i]) reg_disable[i] <= ~bus.wdata[i];
                        end
                        relay_on <= bus.wdata[16];
                    end
                    `REG_TIMEOUT: wdog_period <= bus.wdata[15:0];
                    `REG_DIGIOUT: dout        <= bus.wdata[3:0];
                    `REG_PROMCMD: prom_cmd    <= bus.wdata;
                    default: ;                                 // read only
                endcase
            end
            // external clear beats a command write
            if (prom_cmd_clear) prom_cmd <= '0;
        end
    end

    assign amp_disable = timeout ? '1 : reg_disable;   // watchdog kills all axes

    // ----------------------------------------------------------
    // read mux
    // ----------------------------------------------------------
    always_comb begin
        status_word                    = '0;
        status_word[`STAT_PWR_BIT]     = pwr_enable;
        status_word[`STAT_RELAY_BIT]   = relay_on;
        status_word[27:24]             = board_id;
        status_word[`STAT_TIMEOUT_BIT] = timeout;
        status_word[19:16]             = fault;
        status_word[3:0]               = ~reg_disable;   // enables read back
    end

    always_comb begin
        // limits, home and supply status unless a known register is hit
        rd_mux = {17'd0, relay, mv_good, v_fault, neg_limit, pos_limit, home};
        if (ch0) begin
            case (idx)
                `REG_STATUS:     rd_mux = status_word;
                `REG_TIMEOUT:    rd_mux = {16'd0, wdog_period};
                `REG_VERSION:    rd_mux = `BOARD_VERSION;
                `REG_TEMPSNS:    rd_mux = {16'd0, temp_sense};
                `REG_DIGIOUT:    rd_mux = {28'd0, dout};
                `REG_FW_VERSION: rd_mux = `FW_VERSION;
                `REG_PROMCMD:    rd_mux = prom_cmd;
                `REG_PROMRES:    rd_mux = prom_result;
                default: ;
            endcase
        end
    end

    // sampled on any access, so a write returns the prior value
    always_ff @(posedge sysclk) begin
        if (bus.rd_en || bus.wr_en) begin
            bus.rdata <= rd_mux;
        end
    end

    // each access arrives as a single cycle strobe
    strobe_one_cycle: assert property (@(posedge sysclk) disable iff (!reset)
        (bus.wr_en || bus.rd_en) |=> !(bus.wr_en || bus.rd_en))
        else $error("register bus strobe held longer than one cycle");

endmodule

// File: logic/host_reg_port.sv
/*
 * host side register port
 *   four-phase req/ack handshake with the host
 *   one strobe per request on the internal bus
 *   read result latched for host_rdata
 */

`timescale 1ns/1ps

module host_reg_port (
    input  logic                 sysclk,
    input  logic                 reset,         // sync, active low
    input  logic                 host_req,
    input  logic                 host_we,
    input  board_pkg::reg_addr_t host_addr,
    input  board_pkg::reg_word_t host_wdata,
    output logic                 host_ack,
    output board_pkg::reg_word_t host_rdata,
    reg_bus_if.master            bus
);

    board_pkg::port_state_t state;

    // request held for the access
    logic                 we_q;
    board_pkg::reg_addr_t addr_q;
    board_pkg::reg_word_t wdata_q;

    // ----------------------------------------------------------
    // handshake FSM
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state <= board_pkg::IDLE;
        end else begin
            case (state)
                board_pkg::IDLE:
                    if (host_req) state <= board_pkg::ACCESS;   // req sampled
                board_pkg::ACCESS:
                    state <= board_pkg::RESPOND;                // strobe out
                board_pkg::RESPOND:
                    state <= board_pkg::RELEASE;                // rdata captured
                board_pkg::RELEASE:
                    if (!host_req) state <= board_pkg::IDLE;    // host let go
                default:
                    state <= board_pkg::IDLE;
            endcase
        end
    end

    // latch the request when it is accepted
    always_ff @(posedge sysclk) begin
        if (state == board_pkg::IDLE && host_req) begin
            we_q    <= host_we;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
        if (state == board_pkg::RESPOND) begin
            host_rdata <= bus.rdata;    // prior value on a write
        end
    end

    // ----------------------------------------------------------
    // internal bus drive
    // ----------------------------------------------------------
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.wr_en = (state == board_pkg::ACCESS) &&  we_q;
    assign bus.rd_en = (state == board_pkg::ACCESS) && !we_q;

    assign host_ack = (state == board_pkg::RELEASE);   // held under back-pressure

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(host_ack) |-> host_req)
        else $error("host_ack rose without host_req");

    // host keeps the request fields steady until ack
    req_fields_stable: assert property (@(posedge sysclk) disable iff (!reset)
        (host_req && !host_ack) |=> $stable({host_we, host_addr, host_wdata}))
        else $error("host request changed before host_ack");

endmodule

// File: logic/reg_bus_if.sv
/*
 * internal register bus between host port and register file
 * modports: master (host port), slave (register file),
 * monitor (watchdog, write strobe only)
 */

`timescale 1ns/1ps

interface reg_bus_if;

    board_pkg::reg_addr_t addr;     // channel and index
    board_pkg::reg_word_t wdata;    // write data
    logic                 wr_en;    // one cycle write strobe
    logic                 rd_en;    // one cycle read strobe
    board_pkg::reg_word_t rdata;    // valid the cycle after rd_en

    modport master (
        output addr,
        output wdata,
        output wr_en,
        output rd_en,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  wr_en,
        input  rd_en,
        output rdata
    );

    // watchdog only cares that a write happened
    modport monitor (
        input  wr_en
    );

endinterface

// File: logic/watchdog_timer.sv
/*
 * register write watchdog
 *   tick prescaler restarted on every write
 *   tick counter against the programmed period
 *   sticky timeout cleared by the next write
 */

`timescale 1ns/1ps

`include "board_defines.svh"

module watchdog_timer #(
    parameter int tick_bits = `WDOG_TICK_BITS      // log2 sysclk per tick
) (
    input  logic                   sysclk,
    input  logic                   reset,          // sync, active low
    input  board_pkg::wdog_count_t period,         // 0 = watchdog off
    output logic                   timeout,
    reg_bus_if.monitor             bus
);

    logic [tick_bits-1:0]   prescale;
    logic                   tick;
    board_pkg::wdog_count_t count;     // ticks since last write

    assign tick = &prescale;           // one per 2^tick_bits cycles

    // ----------------------------------------------------------
    // prescaler and timeout counter
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            prescale <= '0;
            count    <= '0;
            timeout  <= 1'b0;
        end else if (bus.wr_en) begin
            // any write restarts the whole timer
            prescale <= '0;
            count    <= '0;
            timeout  <= 1'b0;
        end else begin
            prescale <= prescale + 1'b1;
            if (tick && period != '0) begin
                if (count < period)
                    count <= count + 1'b1;     // still inside window
                else
                    timeout <= 1'b1;           // sticky until next write
            end
        end
    end

    // expiry lands exactly on a nonzero programmed period
    expire_at_period: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(timeout) |-> (period != '0 && count == period))
        else $error("watchdog timeout with period zero or count off the period");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the board register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f board_ctrl.f --top-module board_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vboard_ctrl_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
